// ==== logic/framerPkg.sv ====
package framerPkg;

    // register space select, compared against addr[12:4]
    localparam logic [8:0] framerBase = 9'h0c4;

    // register offsets inside the space
    localparam logic [3:0] regControl = 4'd0;
    localparam logic [3:0] regSyncword = 4'd1;
    localparam logic [3:0] regSyncMask = 4'd2;
    localparam logic [3:0] regStatus = 4'd3;
    localparam logic [3:0] regSourceSelect = 4'd4;

    // control register fields
    localparam int ctrlWordLsb = 0;
    localparam int ctrlWordMsb = 4;
    localparam int ctrlThreshLsb = 8;
    localparam int ctrlThreshMsb = 14;
    localparam int ctrlFramesLsb = 16;
    localparam int ctrlFramesMsb = 31;

    // status register fields
    localparam int statusSyncBit = 0;
    localparam int statusStateLsb = 4;
    localparam int statusInvertBit = 8;

    // sync pattern and the correlation counts
    localparam int syncLength = 32;
    localparam int matchCountWidth = $clog2(syncLength + 1);

    // serial inputs
    localparam int sourceCount = 4;
    localparam int sourceIndexWidth = $clog2(sourceCount);
    localparam int selectWidth = 4;

    // output words are right-justified in this width
    localparam int wordWidth = 32;

    // (bitsPerWord+1) * (wordsPerFrame+1) needs 6 + 17 bits
    localparam int frameCountWidth = 23;

    typedef enum logic [1:0] {
        syncSearch = 2'd0,
        syncVerify = 2'd1,
        syncLocked = 2'd2,
        syncFlywheel = 2'd3
    } syncStateT;

endpackage

// ==== logic/framerIfs.sv ====
// configuration fields, driven by the register block
interface framerCfgIf;
    import framerPkg::*;

    logic [ctrlWordMsb-ctrlWordLsb:0] bitsPerWord;
    logic [ctrlFramesMsb-ctrlFramesLsb:0] wordsPerFrame;
    logic [syncLength-1:0] syncword;
    logic [syncLength-1:0] syncwordMask;
    logic signed [ctrlThreshMsb-ctrlThreshLsb:0] syncThreshold;
    logic [selectWidth-1:0] inputSourceSelect;

    modport regs (
        output bitsPerWord,
        output wordsPerFrame,
        output syncword,
        output syncwordMask,
        output syncThreshold,
        output inputSourceSelect
    );

    modport user (
        input bitsPerWord,
        input wordsPerFrame,
        input syncword,
        input syncwordMask,
        input syncThreshold,
        input inputSourceSelect
    );

endinterface

// per-bit correlation result, match flags only valid with bitValid
interface corrResultIf;
    logic bitValid;
    logic bitData;
    logic matchTrue;
    logic matchInverted;

    modport source (output bitValid, output bitData, output matchTrue, output matchInverted);
    modport sink (input bitValid, input bitData, input matchTrue, input matchInverted);

endinterface

// ==== logic/framerRegs.sv ====
module framerRegs (
    input  logic                busClk,
    input  logic                reset,
    input  logic                cs,
    input  logic                wr0,
    input  logic                wr1,
    input  logic                wr2,
    input  logic                wr3,
    input  logic [12:0]         addr,
    input  logic [31:0]         din,
    output logic [31:0]         dout,
    framerCfgIf.regs            cfg,
    input  logic                framesync,
    input  framerPkg::syncStateT syncState,
    input  logic                invertData
);
    import framerPkg::*;

    logic inSpace;
    logic [3:0] offset;
    logic [3:0] laneWr;

    // replace only the byte lanes that are strobed
    function automatic logic [31:0] mergeLanes(
        input logic [31:0] oldValue,
        input logic [31:0] newValue,
        input logic [3:0] lanes
    );
        logic [31:0] merged;
        merged = oldValue;
        for (int lane = 0; lane < 4; lane++) begin
            if (lanes[lane]) begin
                merged[8*lane +: 8] = newValue[8*lane +: 8];
            end
        end
        return merged;
    endfunction

    assign inSpace = cs && (addr[12:4] == framerBase);
    assign offset = addr[3:0];
    assign laneWr = {wr3, wr2, wr1, wr0} & {4{inSpace}};

    always_ff @(posedge busClk) begin
        if (reset) begin
            cfg.bitsPerWord <= '0;
            cfg.syncThreshold <= '0;
            cfg.wordsPerFrame <= '0;
            cfg.syncword <= '0;
            cfg.syncwordMask <= '0;
            cfg.inputSourceSelect <= '0;
        end else begin
            case (offset)
                regControl: begin
                    // each control field sits in its own byte lane
                    if (laneWr[0]) begin
                        cfg.bitsPerWord <= din[ctrlWordMsb:ctrlWordLsb];
                    end
                    if (laneWr[1]) begin
                        cfg.syncThreshold <= din[ctrlThreshMsb:ctrlThreshLsb];
                    end
                    if (laneWr[2]) begin
                        cfg.wordsPerFrame[7:0] <= din[ctrlFramesLsb +: 8];
                    end
                    if (laneWr[3]) begin
                        cfg.wordsPerFrame[15:8] <= din[ctrlFramesLsb+8 +: 8];
                    end
                end
                regSyncword: begin
                    cfg.syncword <= mergeLanes(cfg.syncword, din, laneWr);
                end
                regSyncMask: begin
                    cfg.syncwordMask <= mergeLanes(cfg.syncwordMask, din, laneWr);
                end
                regSourceSelect: begin
                    if (laneWr[0]) begin
                        cfg.inputSourceSelect <= din[selectWidth-1:0];
                    end
                end
                default: ;
            endcase
        end
    end

    // read mux, zero outside the space and at unused offsets
    always_comb begin
        dout = '0;
        if (inSpace) begin
            case (offset)
                regControl: begin
                    dout[ctrlWordMsb:ctrlWordLsb] = cfg.bitsPerWord;
                    dout[ctrlThreshMsb:ctrlThreshLsb] = cfg.syncThreshold;
                    dout[ctrlFramesMsb:ctrlFramesLsb] = cfg.wordsPerFrame;
                end
                regSyncword: dout = cfg.syncword;
                regSyncMask: dout = cfg.syncwordMask;
                regStatus: begin
                    dout[statusSyncBit] = framesync;
                    dout[statusStateLsb +: 2] = syncState;
                    dout[statusInvertBit] = invertData;
                end
                regSourceSelect: dout[selectWidth-1:0] = cfg.inputSourceSelect;
                default: ;
            endcase
        end
    end

endmodule

// ==== logic/syncCorrelator.sv ====
module syncCorrelator (
    input  logic                                busClk,
    input  logic                                reset,
    input  logic [framerPkg::sourceCount-1:0]   serialData,
    input  logic [framerPkg::sourceCount-1:0]   serialEnable,
    framerCfgIf.user                            cfg,
    corrResultIf.source                         corr
);
    import framerPkg::*;

    logic sourceOk;
    logic bitEnable;
    logic bitIn;
    logic [syncLength-1:0] history;
    logic [syncLength-1:0] nextHistory;
    logic [matchCountWidth-1:0] mismatchCount;
    logic [matchCountWidth-1:0] maskedCount;
    logic [matchCountWidth-1:0] agreeCount;
    logic thresholdOk;

    function automatic logic [matchCountWidth-1:0] popCount(input logic [syncLength-1:0] bits);
        logic [matchCountWidth-1:0] total;
        total = '0;
        for (int i = 0; i < syncLength; i++) begin
            total = total + bits[i];
        end
        return total;
    endfunction

    // select values past the last source take no bits
    assign sourceOk = cfg.inputSourceSelect < sourceCount;
    assign bitEnable = sourceOk && serialEnable[cfg.inputSourceSelect[sourceIndexWidth-1:0]];
    assign bitIn = serialData[cfg.inputSourceSelect[sourceIndexWidth-1:0]];

    // compare including the bit being accepted this cycle
    assign nextHistory = {history[syncLength-2:0], bitIn};
    assign mismatchCount = popCount((nextHistory ^ cfg.syncword) & cfg.syncwordMask);
    assign maskedCount = popCount(cfg.syncwordMask);
    assign agreeCount = maskedCount - mismatchCount;

    // negative threshold turns matching off
    assign thresholdOk = cfg.syncThreshold >= 0;

    always_ff @(posedge busClk) begin
        if (reset) begin
            history <= '0;
            corr.bitValid <= 1'b0;
            corr.bitData <= 1'b0;
            corr.matchTrue <= 1'b0;
            corr.matchInverted <= 1'b0;
        end else begin
            corr.bitValid <= bitEnable;
            if (bitEnable) begin
                history <= nextHistory;
                corr.bitData <= bitIn;
                corr.matchTrue <= thresholdOk &&
                    ($signed({1'b0, mismatchCount}) <= cfg.syncThreshold);
                // inverted stream agrees where the true stream disagrees
                corr.matchInverted <= thresholdOk &&
                    ($signed({1'b0, agreeCount}) <= cfg.syncThreshold);
            end
        end
    end

endmodule

// ==== logic/frameSyncFsm.sv ====
module frameSyncFsm (
    input  logic                    busClk,
    input  logic                    reset,
    framerCfgIf.user                cfg,
    corrResultIf.sink               corr,
    output framerPkg::syncStateT    syncState,
    output logic                    framesync,
    output logic                    invertData,
    output logic                    frameMark
);
    import framerPkg::*;

    logic bitSeen;
    logic seenTrue;
    logic seenInverted;
    logic [5:0] wordBits;
    logic [16:0] frameWords;
    logic [frameCountWidth-1:0] frameBits;
    logic [frameCountWidth-1:0] lastBit;
    logic [frameCountWidth-1:0] bitCount;
    logic atExpected;
    logic polarityMatch;
    syncStateT nextState;
    logic nextInvert;
    logic markNow;

    // frame length in bits, the sync word's last bit closes each frame
    assign wordBits = {1'b0, cfg.bitsPerWord} + 6'd1;
    assign frameWords = {1'b0, cfg.wordsPerFrame} + 17'd1;
    assign frameBits = wordBits * frameWords;
    assign lastBit = frameBits - 1'b1;

    assign atExpected = bitCount == lastBit;
    assign polarityMatch = invertData ? seenInverted : seenTrue;
    assign framesync = (syncState == syncLocked) || (syncState == syncFlywheel);

    always_comb begin
        nextState = syncState;
        nextInvert = invertData;
        markNow = 1'b0;
        if (bitSeen) begin
            if (syncState == syncSearch) begin
                // acquire on either polarity, true wins a tie
                if (seenTrue || seenInverted) begin
                    nextState = syncVerify;
                    nextInvert = !seenTrue;
                    markNow = 1'b1;
                end
            end else if (atExpected) begin
                markNow = 1'b1;
                if (polarityMatch) begin
                    nextState = syncLocked;
                end else if (syncState == syncLocked) begin
                    nextState = syncFlywheel;
                end else begin
                    // verify or a second miss in flywheel
                    nextState = syncSearch;
                end
            end
        end
    end

    // correlation flags are staged once before the decision
    always_ff @(posedge busClk) begin
        seenTrue <= corr.matchTrue;
        seenInverted <= corr.matchInverted;
    end

    always_ff @(posedge busClk) begin
        if (reset) begin
            bitSeen <= 1'b0;
            syncState <= syncSearch;
            invertData <= 1'b0;
            frameMark <= 1'b0;
            bitCount <= '0;
        end else begin
            bitSeen <= corr.bitValid;
            syncState <= nextState;
            invertData <= nextInvert;
            frameMark <= markNow;
            if (markNow) begin
                bitCount <= '0;
            end else if (bitSeen && (syncState != syncSearch)) begin
                bitCount <= bitCount + 1'b1;
            end
        end
    end

endmodule

// ==== logic/wordAssembler.sv ====
module wordAssembler (
    input  logic                                busClk,
    input  logic                                reset,
    framerCfgIf.user                            cfg,
    corrResultIf.sink                           corr,
    input  framerPkg::syncStateT                syncState,
    input  logic                                invertData,
    input  logic                                frameMark,
    output logic [framerPkg::wordWidth-1:0]     wordOut,
    output logic                                wordValid,
    output logic                                frameStart
);
    import framerPkg::*;

    logic bitHeld;
    logic dataHeld;
    logic bodyBit;
    logic wordDone;
    logic startArmed;
    logic [ctrlWordMsb-ctrlWordLsb:0] bitCount;
    logic [ctrlWordMsb-ctrlWordLsb:0] baseCount;
    logic [wordWidth-1:0] packReg;
    logic [wordWidth-1:0] basePack;
    logic [wordWidth-1:0] nextPack;

    // bits are packed only while the frame is being tracked
    assign bodyBit = bitHeld && (syncState != syncSearch);

    // frameMark restarts packing with the bit held now
    assign baseCount = frameMark ? '0 : bitCount;
    assign basePack = frameMark ? '0 : packReg;
    assign nextPack = {basePack[wordWidth-2:0], dataHeld ^ invertData};
    assign wordDone = bodyBit && (baseCount == cfg.bitsPerWord);

    always_ff @(posedge busClk) begin
        dataHeld <= corr.bitData;
        // packing starts from zero so the word stays right-justified
        if (wordDone) begin
            wordOut <= nextPack;
            packReg <= '0;
        end else if (bodyBit) begin
            packReg <= nextPack;
        end else begin
            packReg <= basePack;
        end
    end

    always_ff @(posedge busClk) begin
        if (reset) begin
            bitHeld <= 1'b0;
            bitCount <= '0;
            startArmed <= 1'b0;
            wordValid <= 1'b0;
            frameStart <= 1'b0;
        end else begin
            bitHeld <= corr.bitValid;
            wordValid <= wordDone;
            frameStart <= wordDone && (startArmed || frameMark);
            if (wordDone) begin
                bitCount <= '0;
                startArmed <= 1'b0;
            end else begin
                bitCount <= bodyBit ? baseCount + 1'b1 : baseCount;
                if (frameMark) begin
                    startArmed <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/framerTop.sv ====
module framerTop (
    input  logic                                busClk,
    input  logic                                reset,
    input  logic                                cs,
    input  logic                                wr0,
    input  logic                                wr1,
    input  logic                                wr2,
    input  logic                                wr3,
    input  logic [12:0]                         addr,
    input  logic [31:0]                         din,
    output logic [31:0]                         dout,
    input  logic [framerPkg::sourceCount-1:0]   serialData,
    input  logic [framerPkg::sourceCount-1:0]   serialEnable,
    output logic [framerPkg::wordWidth-1:0]     wordOut,
    output logic                                wordValid,
    output logic                                frameStart,
    output logic                                framesync,
    output framerPkg::syncStateT                syncState,
    output logic                                invertData
);

    // restart strobe from the sync FSM to the word packer
    logic frameMark;

    framerCfgIf cfgBus ();
    corrResultIf corrBus ();

    framerRegs regs0 (
        .busClk(busClk),
        .reset(reset),
        .cs(cs),
        .wr0(wr0),
        .wr1(wr1),
        .wr2(wr2),
        .wr3(wr3),
        .addr(addr),
        .din(din),
        .dout(dout),
        .cfg(cfgBus.regs),
        .framesync(framesync),
        .syncState(syncState),
        .invertData(invertData)
    );

    syncCorrelator corr0 (
        .busClk(busClk),
        .reset(reset),
        .serialData(serialData),
        .serialEnable(serialEnable),
        .cfg(cfgBus.user),
        .corr(corrBus.source)
    );

    frameSyncFsm fsm0 (
        .busClk(busClk),
        .reset(reset),
        .cfg(cfgBus.user),
        .corr(corrBus.sink),
        .syncState(syncState),
        .framesync(framesync),
        .invertData(invertData),
        .frameMark(frameMark)
    );

    wordAssembler words0 (
        .busClk(busClk),
        .reset(reset),
        .cfg(cfgBus.user),
        .corr(corrBus.sink),
        .syncState(syncState),
        .invertData(invertData),
        .frameMark(frameMark),
        .wordOut(wordOut),
        .wordValid(wordValid),
        .frameStart(frameStart)
    );

endmodule

// ==== bench/framerChecker.sv ====
module framerChecker (
    input logic        busClk,
    input logic        reset,
    input logic        cs,
    input logic        wr0,
    input logic        wr1,
    input logic        wr2,
    input logic        wr3,
    input logic [12:0] addr,
    input logic [31:0] din,
    input logic [31:0] dout,
    input logic [3:0]  serialData,
    input logic [3:0]  serialEnable,
    input logic [31:0] wordOut,
    input logic        wordValid,
    input logic        frameStart,
    input logic        framesync,
    input logic [1:0]  syncState,
    input logic        invertData
);
    logic [31:0] ctrlReg;
    logic [31:0] syncReg;
    logic [31:0] maskReg;
    logic [3:0] selReg;
    logic [31:0] hist;
    logic [31:0] word;
    logic [1:0] st;
    logic inv;
    logic startArm;
    logic seenReset = 1'b0;
    // model state delayed to line up with the DUT
    // bit 2 of each stage holds the polarity
    logic [2:0] d1;
    logic [2:0] d2;
    logic [2:0] d3;
    int cnt;
    int nb;
    logic [32:0] expWords[$];
    string testName = "reset";
    int testErrors = 0;
    int passCount = 0;
    int failCount = 0;

    function automatic int ones(input logic [31:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            n += v[i];
        end
        return n;
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] a, input logic [31:0] b,
                                          input logic [3:0] lanes);
        logic [31:0] r;
        r = a;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                r[8*i +: 8] = b[8*i +: 8];
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] readModel();
        logic [31:0] r;
        r = '0;
        if (cs && addr[12:4] == framerPkg::framerBase) begin
            case (addr[3:0])
                4'd0: r = ctrlReg;
                4'd1: r = syncReg;
                4'd2: r = maskReg;
                4'd3: begin
                    r[0] = d3[1];
                    r[5:4] = d3[1:0];
                    r[8] = d3[2];
                end
                4'd4: r[3:0] = selReg;
                default: r = '0;
            endcase
        end
        return r;
    endfunction

    function automatic int pendingWords();
        return expWords.size();
    endfunction

    task automatic checkValue(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s %s expected %h actual %h", testName, what, exp, act);
            testErrors++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("%s in test %s", msg, testName);
        testErrors++;
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        if (expWords.size() != 0) begin
            reportProblem("words were expected but never came out");
        end
        if (testErrors == 0) begin
            passCount++;
            $display("test %s passed", testName);
        end else begin
            failCount++;
            $display("test %s failed with %0d errors", testName, testErrors);
        end
    endtask

    // one accepted bit through correlation, sync rules and packing
    task automatic takeBit(input logic b);
        int thr;
        int mis;
        int agr;
        int frameBits;
        logic mt;
        logic mi;
        thr = $signed(ctrlReg[14:8]);
        hist = {hist[30:0], b};
        mis = ones((hist ^ syncReg) & maskReg);
        agr = ones(maskReg) - mis;
        mt = (thr >= 0) && (mis <= thr);
        mi = (thr >= 0) && (agr <= thr);
        frameBits = (ctrlReg[4:0] + 1) * (ctrlReg[31:16] + 1);
        if (st == 2'd0) begin
            if (mt || mi) begin
                st = 2'd1;
                inv = !mt;
                cnt = 0;
                nb = 0;
                word = '0;
                startArm = 1'b1;
            end
        end else begin
            word = (word << 1) | (b ^ inv);
            nb++;
            if (nb == ctrlReg[4:0] + 1) begin
                expWords.push_back({startArm, word});
                startArm = 1'b0;
                nb = 0;
                word = '0;
            end
            if (cnt == frameBits - 1) begin
                cnt = 0;
                nb = 0;
                word = '0;
                startArm = 1'b1;
                if (inv ? mi : mt) begin
                    st = 2'd2;
                end else if (st == 2'd2) begin
                    st = 2'd3;
                end else begin
                    st = 2'd0;
                end
            end else begin
                cnt++;
            end
        end
    endtask

    always @(posedge busClk) begin
        if (reset) begin
            ctrlReg = '0;
            syncReg = '0;
            maskReg = '0;
            selReg = '0;
            hist = '0;
            word = '0;
            st = 2'd0;
            inv = 1'b0;
            startArm = 1'b0;
            cnt = 0;
            nb = 0;
            d1 = '0;
            d2 = '0;
            d3 = '0;
            expWords.delete();
            seenReset = 1'b1;
        end else begin
            d3 = d2;
            d2 = d1;
            if (selReg < 4 && serialEnable[selReg[1:0]]) begin
                takeBit(serialData[selReg[1:0]]);
            end
            d1 = {inv, st};
            if (cs && addr[12:4] == framerPkg::framerBase) begin
                case (addr[3:0])
                    4'd0: ctrlReg = merge(ctrlReg, din, {wr3, wr2, wr1, wr0}) & 32'hffff_7f1f;
                    4'd1: syncReg = merge(syncReg, din, {wr3, wr2, wr1, wr0});
                    4'd2: maskReg = merge(maskReg, din, {wr3, wr2, wr1, wr0});
                    4'd4: if (wr0) selReg = din[3:0];
                    default: ;
                endcase
            end
        end
    end

    // outputs are compared mid-cycle where they are stable
    always @(negedge busClk) begin
        logic [32:0] e;
        if (!reset && seenReset) begin
            checkValue("syncState", d3[1:0], syncState);
            checkValue("framesync", d3[1], framesync);
            checkValue("invertData", d3[2], invertData);
            if (cs && !(wr0 || wr1 || wr2 || wr3)) begin
                checkValue("read data", readModel(), dout);
            end
            if (wordValid) begin
                if (expWords.size() == 0) begin
                    reportProblem("a word came out when none was expected");
                end else begin
                    e = expWords.pop_front();
                    checkValue("wordOut", e[31:0], wordOut);
                    checkValue("frameStart", e[32], frameStart);
                end
            end else begin
                checkValue("frameStart", 1'b0, frameStart);
            end
        end
    end

endmodule

// ==== bench/framerTb.sv ====
module framerTb;
    import framerPkg::*;

    logic busClk;
    logic reset;
    logic cs;
    logic wr0;
    logic wr1;
    logic wr2;
    logic wr3;
    logic [12:0] addr;
    logic [31:0] din;
    logic [31:0] dout;
    logic [3:0] serialData;
    logic [3:0] serialEnable;
    logic [31:0] wordOut;
    logic wordValid;
    logic frameStart;
    logic framesync;
    logic invertData;
    syncStateT syncState;
    int srcSel;
    int frameBits;

    framerTop dut0 (.*);
    framerChecker chk0 (.*);

    initial begin
        busClk = 1'b0;
        forever #50 busClk = ~busClk;
    end

    // reset is held for three rising edges
    task automatic applyReset();
        @(posedge busClk);
        reset <= 1'b1;
        serialEnable <= '0;
        repeat (3) @(posedge busClk);
        reset <= 1'b0;
    endtask

    task automatic busWrite(input logic [3:0] off, input logic [31:0] data,
                            input logic [3:0] lanes);
        @(posedge busClk);
        cs <= 1'b1;
        addr <= {framerBase, off};
        din <= data;
        {wr3, wr2, wr1, wr0} <= lanes;
        @(posedge busClk);
        cs <= 1'b0;
        {wr3, wr2, wr1, wr0} <= 4'h0;
    endtask

    // the checker compares dout during the read cycle
    task automatic busRead(input logic [12:0] a);
        @(posedge busClk);
        cs <= 1'b1;
        addr <= a;
        {wr3, wr2, wr1, wr0} <= 4'h0;
        @(posedge busClk);
        cs <= 1'b0;
    endtask

    task automatic setup(input int bpw, input int thr, input int wpf, input logic [31:0] sw,
                         input logic [31:0] mask);
        logic [31:0] ctrl;
        ctrl = '0;
        ctrl[4:0] = bpw;
        ctrl[14:8] = thr;
        ctrl[31:16] = wpf;
        srcSel = $urandom % 4;
        busWrite(regControl, ctrl, 4'hf);
        busWrite(regSyncword, sw, 4'hf);
        busWrite(regSyncMask, mask, 4'hf);
        busWrite(regSourceSelect, srcSel, 4'h1);
        frameBits = (bpw + 1) * (wpf + 1);
    endtask

    // other sources carry noise while the selected one sees gaps of up to two cycles
    task automatic sendBit(input logic b);
        logic [3:0] dat;
        logic [3:0] en;
        repeat ($urandom % 3) begin
            @(posedge busClk);
            en = $urandom;
            en[srcSel] = 1'b0;
            serialEnable <= en;
            serialData <= $urandom;
        end
        @(posedge busClk);
        dat = $urandom;
        en = $urandom;
        dat[srcSel] = b;
        en[srcSel] = 1'b1;
        serialData <= dat;
        serialEnable <= en;
    endtask

    task automatic sendWord(input logic [31:0] value);
        for (int i = 31; i >= 0; i--) begin
            sendBit(value[i]);
        end
    endtask

    task automatic sendFrame(input logic [31:0] sw, input logic [31:0] err, input logic inv);
        repeat (frameBits - 32) sendBit($urandom % 2);
        sendWord(sw ^ err ^ {32{inv}});
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge busClk);
            serialEnable <= '0;
        end
    endtask

    task automatic waitState(input syncStateT target, input int limit);
        int i;
        i = 0;
        while (syncState !== target && i < limit) begin
            @(negedge busClk);
            i++;
        end
        if (syncState !== target) begin
            chk0.reportProblem("timed out waiting for the sync state");
        end
    endtask

    task automatic waitDrain(input int limit);
        int i;
        i = 0;
        while (chk0.pendingWords() != 0 && i < limit) begin
            @(negedge busClk);
            i++;
        end
        if (chk0.pendingWords() != 0) begin
            chk0.reportProblem("timed out waiting for words");
        end
    endtask

    task automatic runLock(input string name, input int bpw, input int wpf, input logic inv);
        logic [31:0] sw;
        applyReset();
        chk0.beginTest(name);
        sw = $urandom;
        setup(bpw, 2, wpf, sw, 32'hffff_ffff);
        sendWord(sw ^ {32{inv}});
        repeat (3) sendFrame(sw, 32'h0, inv);
        idle(4);
        waitState(syncLocked, 50);
        chk0.checkValue("invertData", inv, invertData);
        busRead({framerBase, regStatus});
        waitDrain(50);
        chk0.endTest();
    endtask

    initial begin
        logic [31:0] sw;
        logic [31:0] mask;
        logic [31:0] err;
        int placed;
        int pos;
        void'($urandom(32'haf4e_a371));
        reset = 1'b1;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'h0;
        addr = '0;
        din = '0;
        serialData = '0;
        serialEnable = '0;
        srcSel = 0;
        frameBits = 64;

        repeat (3) @(posedge busClk);
        reset <= 1'b0;
        chk0.beginTest("registers");
        repeat (24) busWrite($urandom % 6, $urandom, $urandom % 16);
        for (int o = 0; o < 16; o++) begin
            busRead({framerBase, o[3:0]});
        end
        busRead({framerBase ^ 9'h001, 4'd1});
        chk0.endTest();

        runLock("acquire", 7, 7, 1'b0);
        runLock("words12", 11, 5, 1'b0);
        runLock("words32", 31, 2, 1'b0);
        runLock("inverted", 15, 3, 1'b1);

        chk0.beginTest("tolerance");
        for (int k = 0; k <= 5; k++) begin
            applyReset();
            sw = $urandom;
            mask = $urandom | 32'h0000_ffff;
            setup(7, 3, 7, sw, mask);
            // masked-off errors never count
            err = ~mask & $urandom;
            placed = 0;
            while (placed < k) begin
                pos = $urandom % 32;
                if (mask[pos] && !err[pos]) begin
                    err[pos] = 1'b1;
                    placed++;
                end
            end
            sendWord(sw ^ err);
            idle(6);
            chk0.checkValue("state", (k <= 3) ? syncVerify : syncSearch, syncState);
        end
        applyReset();
        sw = $urandom;
        setup(7, -1, 7, sw, 32'hffff_ffff);
        sendWord(sw);
        repeat (2) sendFrame(sw, 32'h0, 1'b0);
        idle(6);
        chk0.checkValue("negative threshold state", syncSearch, syncState);
        chk0.endTest();

        applyReset();
        chk0.beginTest("loss");
        sw = $urandom;
        setup(15, 1, 3, sw, 32'hffff_ffff);
        sendWord(sw);
        repeat (3) sendFrame(sw, 32'h0, 1'b0);
        idle(4);
        waitState(syncLocked, 50);
        sendFrame(sw, 32'h00ff_00ff, 1'b0);
        idle(6);
        chk0.checkValue("state", syncFlywheel, syncState);
        busRead({framerBase, regStatus});
        sendFrame(sw, 32'h0f0f_0f0f, 1'b0);
        idle(6);
        chk0.checkValue("state", syncSearch, syncState);
        chk0.checkValue("framesync", 1'b0, framesync);
        waitDrain(50);
        chk0.endTest();

        $display("%0d tests passed, %0d tests failed", chk0.passCount, chk0.failCount);
        if (chk0.failCount == 0 && chk0.passCount > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
logic/framerPkg.sv
logic/framerIfs.sv
logic/framerRegs.sv
logic/syncCorrelator.sv
logic/frameSyncFsm.sv
logic/wordAssembler.sv
logic/framerTop.sv
bench/framerChecker.sv
bench/framerTb.sv
